// File: source/mem_access_pkg.sv
`default_nettype none

package mem_access_pkg;

	// ==================================================
	// default bus widths, overridden from the top level
	// ==================================================
	parameter int ADDR_WIDTH = 16;
	parameter int DATA_WIDTH = 32;

	// ==================================================
	// bus guard FSM states
	// ==================================================
	typedef enum logic [1:0] {
		guard_idle,	// choose a request
		guard_issue,	// mem_req pulse
		guard_wait,	// wait for mem_valid or timeout
		guard_done	// result pulse to the client
	} guard_state_t;

	// ==================================================
	// owner of the access currently on the bus
	// ==================================================
	typedef enum logic [1:0] {
		port_instr_read,
		port_data_read,
		port_data_write
	} mem_port_t;

endpackage

`default_nettype wire

// File: source/mem_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// head of one request FIFO as seen by the bus guard
interface mem_req_if #(
	parameter int ADDR_WIDTH = mem_access_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = mem_access_pkg::DATA_WIDTH
);

	logic pending;	// FIFO not empty
	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] wdata;
	logic pop;	// only while pending

	modport fifo_side (output pending, addr, wdata, input pop);
	modport guard_side (input pending, addr, wdata, output pop);

endinterface

`default_nettype wire

// File: source/mem_request_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module mem_request_fifo #(
	parameter int DEPTH = 4,
	parameter int ADDR_WIDTH = mem_access_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = mem_access_pkg::DATA_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [ADDR_WIDTH-1:0] push_addr,
	input logic [DATA_WIDTH-1:0] push_wdata,
	output logic full,
	mem_req_if.fifo_side head
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);
	localparam logic [COUNT_W-1:0] DEPTH_COUNT = COUNT_W'(DEPTH);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	logic [ADDR_WIDTH-1:0] addr_mem [DEPTH];
	logic [DATA_WIDTH-1:0] wdata_mem [DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [COUNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == LAST_PTR) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == DEPTH_COUNT);
	assign do_push = push && !full;	// strobe while full is dropped
	assign do_pop = head.pop && head.pending;

	assign head.pending = (count != '0);
	assign head.addr = addr_mem[rd_ptr];
	assign head.wdata = wdata_mem[rd_ptr];

	// ==================================================
	// storage
	// ==================================================
	always_ff @(posedge clk) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= push_addr;
			wdata_mem[wr_ptr] <= push_wdata;
		end
	end

	// ==================================================
	// pointers and occupancy
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/mem_bus_timer.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bus_timer #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic stop,
	output logic timeout
);

	localparam int COUNT_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [COUNT_W-1:0] LIMIT = COUNT_W'(TIMEOUT_CYCLES);

	logic [COUNT_W-1:0] count;
	logic running;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			running <= 1'b0;
			timeout <= 1'b0;
		end else if (start) begin	// restart wins over stop
			count <= '0;
			running <= 1'b1;
			timeout <= 1'b0;
		end else if (stop) begin
			running <= 1'b0;
			timeout <= 1'b0;
		end else if (running) begin
			count <= count + 1'b1;
			if (count + 1'b1 == LIMIT) begin
				timeout <= 1'b1;	// single pulse, then halt
				running <= 1'b0;
			end
		end else begin
			timeout <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/mem_bus_guard.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bus_guard import mem_access_pkg::*; #(
	parameter int ADDR_WIDTH = mem_access_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = mem_access_pkg::DATA_WIDTH
) (
	input logic clk,
	input logic reset,
	mem_req_if.guard_side instr_rd,
	mem_req_if.guard_side data_rd,
	mem_req_if.guard_side data_wr,
	output logic timer_start,
	output logic timer_stop,
	input logic timeout,
	output logic mem_req,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	input logic mem_valid,
	input logic [DATA_WIDTH-1:0] mem_rdata,
	output logic instr_rd_done,
	output logic data_rd_done,
	output logic data_wr_done,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic error
);

	guard_state_t state;
	guard_state_t state_next;

	mem_port_t owner;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [DATA_WIDTH-1:0] wdata_q;
	logic [DATA_WIDTH-1:0] rd_data_q;
	logic error_q;

	logic any_pending;
	logic in_idle;
	logic in_wait;

	assign any_pending = data_wr.pending | data_rd.pending | instr_rd.pending;
	assign in_idle = (state == guard_idle);
	assign in_wait = (state == guard_wait);

	// ==================================================
	// fixed priority pop: write, data read, instr read
	// ==================================================
	assign data_wr.pop = in_idle && data_wr.pending;
	assign data_rd.pop = in_idle && data_rd.pending && !data_wr.pending;
	assign instr_rd.pop = in_idle && instr_rd.pending
		&& !data_wr.pending && !data_rd.pending;

	always_comb begin
		state_next = state;
		case (state)
			guard_idle: begin
				if (any_pending) begin
					state_next = guard_issue;
				end
			end
			guard_issue: state_next = guard_wait;
			guard_wait: begin
				if (mem_valid || timeout) begin
					state_next = guard_done;
				end
			end
			guard_done: state_next = guard_idle;
			default: state_next = guard_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= guard_idle;
		end else begin
			state <= state_next;
		end
	end

	// latch the chosen head entry and its owner
	always_ff @(posedge clk) begin
		if (in_idle) begin
			if (data_wr.pending) begin
				owner <= port_data_write;
				addr_q <= data_wr.addr;
				wdata_q <= data_wr.wdata;
			end else if (data_rd.pending) begin
				owner <= port_data_read;
				addr_q <= data_rd.addr;
				wdata_q <= data_rd.wdata;
			end else if (instr_rd.pending) begin
				owner <= port_instr_read;
				addr_q <= instr_rd.addr;
				wdata_q <= instr_rd.wdata;
			end
		end
	end

	// ==================================================
	// result capture
	// ==================================================
	always_ff @(posedge clk) begin
		if (in_wait && mem_valid) begin
			rd_data_q <= mem_rdata;
		end else if (in_wait && timeout) begin
			rd_data_q <= '0;	// no answer, report zero
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			error_q <= 1'b0;
		end else if (in_wait && mem_valid) begin	// answer beats a late timeout
			error_q <= 1'b0;
		end else if (in_wait && timeout) begin
			error_q <= 1'b1;
		end
	end

	assign timer_start = (state == guard_issue);
	assign timer_stop = in_wait && mem_valid;

	assign mem_req = (state == guard_issue);
	assign mem_write = mem_req && (owner == port_data_write);
	assign mem_addr = addr_q;
	assign mem_wdata = wdata_q;

	// one result bus, steered by owner
	assign instr_rd_done = (state == guard_done) && (owner == port_instr_read);
	assign data_rd_done = (state == guard_done) && (owner == port_data_read);
	assign data_wr_done = (state == guard_done) && (owner == port_data_write);
	assign rd_data = rd_data_q;
	assign error = error_q;

endmodule

`default_nettype wire

// File: source/mem_access_via_fifos.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_via_fifos #(
	parameter int ADDR_WIDTH = mem_access_pkg::ADDR_WIDTH,
	parameter int DATA_WIDTH = mem_access_pkg::DATA_WIDTH,
	parameter int FIFO_DEPTH = 4,
	parameter int TIMEOUT_CYCLES = 16
) (
	input logic clk,
	input logic reset,
	input logic instr_rd_req,
	input logic data_rd_req,
	input logic data_wr_req,
	input logic [ADDR_WIDTH-1:0] instr_rd_addr,
	input logic [ADDR_WIDTH-1:0] data_rd_addr,
	input logic [ADDR_WIDTH-1:0] data_wr_addr,
	input logic [DATA_WIDTH-1:0] data_wr_data,
	output logic instr_rd_full,
	output logic data_rd_full,
	output logic data_wr_full,
	output logic instr_rd_done,
	output logic data_rd_done,
	output logic data_wr_done,
	output logic [DATA_WIDTH-1:0] rd_data,
	output logic error,
	output logic mem_req,
	output logic mem_write,
	output logic [ADDR_WIDTH-1:0] mem_addr,
	output logic [DATA_WIDTH-1:0] mem_wdata,
	input logic mem_valid,
	input logic [DATA_WIDTH-1:0] mem_rdata
);

	logic timer_start;
	logic timer_stop;
	logic timeout;

	mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) instr_rd_q ();
	mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) data_rd_q ();
	mem_req_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) data_wr_q ();

	// ==================================================
	// client request queues
	// ==================================================
	mem_request_fifo #(
		.DEPTH(FIFO_DEPTH), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) instr_rd_fifo_i (
		.clk(clk), .reset(reset), .push(instr_rd_req),
		.push_addr(instr_rd_addr), .push_wdata('0),	// read, no payload
		.full(instr_rd_full), .head(instr_rd_q.fifo_side)
	);

	mem_request_fifo #(
		.DEPTH(FIFO_DEPTH), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) data_rd_fifo_i (
		.clk(clk), .reset(reset), .push(data_rd_req),
		.push_addr(data_rd_addr), .push_wdata('0),
		.full(data_rd_full), .head(data_rd_q.fifo_side)
	);

	mem_request_fifo #(
		.DEPTH(FIFO_DEPTH), .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
	) data_wr_fifo_i (
		.clk(clk), .reset(reset), .push(data_wr_req),
		.push_addr(data_wr_addr), .push_wdata(data_wr_data),
		.full(data_wr_full), .head(data_wr_q.fifo_side)
	);

	// ==================================================
	// bus guard and its timer
	// ==================================================
	mem_bus_guard #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mem_bus_guard_i (
		.clk(clk), .reset(reset),
		.instr_rd(instr_rd_q.guard_side),
		.data_rd(data_rd_q.guard_side),
		.data_wr(data_wr_q.guard_side),
		.timer_start(timer_start), .timer_stop(timer_stop), .timeout(timeout),
		.mem_req(mem_req), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_valid(mem_valid), .mem_rdata(mem_rdata),
		.instr_rd_done(instr_rd_done), .data_rd_done(data_rd_done),
		.data_wr_done(data_wr_done),
		.rd_data(rd_data), .error(error)
	);

	mem_bus_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) mem_bus_timer_i (
		.clk(clk), .reset(reset),
		.start(timer_start), .stop(timer_stop),
		.timeout(timeout)
	);

endmodule

`default_nettype wire

// File: test/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// memory behind the bus that answers each request after a settable latency
module tb_mem_model #(
	parameter int ADDR_WIDTH = 16,
	parameter int DATA_WIDTH = 32
) (
	input logic clk,
	input logic reset,
	input logic mem_req,
	input logic mem_write,
	input logic [ADDR_WIDTH-1:0] mem_addr,
	input logic [DATA_WIDTH-1:0] mem_wdata,
	input logic [7:0] latency,	// 0 = never answer
	output logic mem_valid,
	output logic [DATA_WIDTH-1:0] mem_rdata
);

	localparam int WORDS = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] words [WORDS];
	logic written [WORDS];
	logic [7:0] countdown;
	logic [DATA_WIDTH-1:0] answer;

	// unwritten words hold the inverted address
	function automatic logic [DATA_WIDTH-1:0] read_word(input logic [ADDR_WIDTH-1:0] addr);
		logic [DATA_WIDTH-1:0] fill;
		fill = '0;
		fill[ADDR_WIDTH-1:0] = ~addr;
		if (written[addr]) begin
			return words[addr];
		end
		return fill;
	endfunction

	initial begin
		written = '{default: 1'b0};
	end

	always @(posedge clk) begin
		if (reset) begin
			countdown <= 8'd0;
			mem_valid <= 1'b0;
			mem_rdata <= '0;
		end else begin
			mem_valid <= 1'b0;
			if (mem_req) begin
				if (mem_write) begin
					words[mem_addr] <= mem_wdata;
					written[mem_addr] = 1'b1;
					answer <= mem_wdata;
				end else begin
					answer <= read_word(mem_addr);
				end
				countdown <= latency;
			end else if (countdown != 8'd0) begin
				countdown <= countdown - 8'd1;
				if (countdown == 8'd1) begin
					mem_valid <= 1'b1;
					mem_rdata <= answer;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: test/tb_mem_access_via_fifos.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_access_via_fifos import mem_access_pkg::*; ();

	localparam int AW = 16;
	localparam int DW = 32;
	localparam int TIMEOUT_CYCLES = 16;
	localparam int NUM_FIXED = 8;
	localparam int NUM_ROWS = 20;

	typedef struct packed {
		mem_port_t port;
		logic [AW-1:0] addr;
		logic [DW-1:0] wdata;
		logic [7:0] latency;
		logic exp_error;
		logic with_next;	// strobed in the same cycle as the next row
	} row_t;

	logic clk;
	logic reset;
	logic instr_rd_req, data_rd_req, data_wr_req;
	logic [AW-1:0] instr_rd_addr, data_rd_addr, data_wr_addr;
	logic [DW-1:0] data_wr_data;
	logic instr_rd_full, data_rd_full, data_wr_full;
	logic instr_rd_done, data_rd_done, data_wr_done;
	logic [DW-1:0] rd_data;
	logic error;
	logic mem_req, mem_write, mem_valid;
	logic [AW-1:0] mem_addr;
	logic [DW-1:0] mem_wdata, mem_rdata;
	logic [7:0] mem_latency;

	row_t rows [NUM_ROWS];
	logic [DW-1:0] ref_mem [1 << AW];
	logic ref_written [1 << AW];
	logic [31:0] rng_state;
	int value_errors;
	int other_errors;
	int cycle_count;
	int cycle_limit;

	mem_access_via_fifos #(
		.ADDR_WIDTH(AW), .DATA_WIDTH(DW), .FIFO_DEPTH(4), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) mem_access_via_fifos_i (
		.clk(clk), .reset(reset),
		.instr_rd_req(instr_rd_req), .data_rd_req(data_rd_req), .data_wr_req(data_wr_req),
		.instr_rd_addr(instr_rd_addr), .data_rd_addr(data_rd_addr),
		.data_wr_addr(data_wr_addr), .data_wr_data(data_wr_data),
		.instr_rd_full(instr_rd_full), .data_rd_full(data_rd_full),
		.data_wr_full(data_wr_full),
		.instr_rd_done(instr_rd_done), .data_rd_done(data_rd_done),
		.data_wr_done(data_wr_done),
		.rd_data(rd_data), .error(error),
		.mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_valid(mem_valid), .mem_rdata(mem_rdata)
	);

	tb_mem_model #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) mem_model_i (
		.clk(clk), .reset(reset), .mem_req(mem_req), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .latency(mem_latency),
		.mem_valid(mem_valid), .mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==================================================
	// helpers
	// ==================================================
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic row_t make_row(input mem_port_t port, input logic [AW-1:0] addr,
			input logic [DW-1:0] wdata, input logic [7:0] latency, input logic exp_error,
			input logic with_next);
		row_t r;
		r.port = port;
		r.addr = addr;
		r.wdata = wdata;
		r.latency = latency;
		r.exp_error = exp_error;
		r.with_next = with_next;
		return r;
	endfunction

	// {write, data read, instr read}
	function automatic logic [2:0] done_mask(input mem_port_t port);
		case (port)
			port_data_write: return 3'b100;
			port_data_read: return 3'b010;
			default: return 3'b001;
		endcase
	endfunction

	function automatic logic [DW-1:0] expected_word(input logic [AW-1:0] addr);
		logic [DW-1:0] fill;
		fill = '0;
		fill[AW-1:0] = ~addr;	// never written
		if (ref_written[addr]) begin
			return ref_mem[addr];
		end
		return fill;
	endfunction

	task automatic build_table();
		logic [31:0] r1;
		logic [31:0] r2;
		mem_port_t pick;
		rows[0] = make_row(port_data_write, 16'h0100, 32'hcafe_0001, 8'd3, 1'b0, 1'b0);
		rows[1] = make_row(port_data_read, 16'h0100, 32'h0, 8'd2, 1'b0, 1'b0);
		rows[2] = make_row(port_instr_read, 16'h1234, 32'h0, 8'd1, 1'b0, 1'b0);
		rows[3] = make_row(port_data_read, 16'h0200, 32'h0, 8'd0, 1'b1, 1'b0);	// no answer
		rows[4] = make_row(port_instr_read, 16'h0200, 32'h0, 8'd4, 1'b0, 1'b0);
		// all three clients in one cycle in priority order
		rows[5] = make_row(port_data_write, 16'h0300, 32'h1357_9bdf, 8'd2, 1'b0, 1'b1);
		rows[6] = make_row(port_data_read, 16'h0300, 32'h0, 8'd3, 1'b0, 1'b1);
		rows[7] = make_row(port_instr_read, 16'h0300, 32'h0, 8'd1, 1'b0, 1'b0);
		rng_state = 32'd84;
		for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
			r1 = next_random(rng_state);
			r2 = next_random(r1);
			rng_state = r2;
			if (r1[17:16] == 2'd0) begin
				pick = port_instr_read;
			end else if (r1[17:16] == 2'd1) begin
				pick = port_data_read;
			end else begin
				pick = port_data_write;
			end
			rows[i] = make_row(pick, {12'h040, r1[7:4]}, r2, {5'd0, r1[2:0]} + 8'd1,
				1'b0, 1'b0);	// small window so reads hit earlier writes
		end
	endtask

	task automatic strobe_group(input int first, input int last);
		for (int r = first; r <= last; r++) begin
			case (rows[r].port)
				port_data_write: begin
					data_wr_req = 1'b1;
					data_wr_addr = rows[r].addr;
					data_wr_data = rows[r].wdata;
				end
				port_data_read: begin
					data_rd_req = 1'b1;
					data_rd_addr = rows[r].addr;
				end
				default: begin
					instr_rd_req = 1'b1;
					instr_rd_addr = rows[r].addr;
				end
			endcase
		end
		mem_latency = rows[first].latency;
		@(negedge clk);
		data_wr_req = 1'b0;
		data_rd_req = 1'b0;
		instr_rd_req = 1'b0;
	endtask

	// request fields on the memory bus during the mem_req cycle
	task automatic check_bus(input int r);
		logic exp_write;
		exp_write = (rows[r].port == port_data_write);
		assert (mem_write == exp_write) else begin
			value_errors++;
			$display("ERROR row %0d mem_write = 0x%h, expected 0x%h", r, mem_write, exp_write);
		end
		assert (mem_addr == rows[r].addr) else begin
			value_errors++;
			$display("ERROR row %0d mem_addr = 0x%h, expected 0x%h", r, mem_addr,
				rows[r].addr);
		end
		if (exp_write) begin
			assert (mem_wdata == rows[r].wdata) else begin
				value_errors++;
				$display("ERROR row %0d mem_wdata = 0x%h, expected 0x%h", r, mem_wdata,
					rows[r].wdata);
			end
		end
	endtask

	task automatic check_row(input int r);
		logic [2:0] done_vec;
		logic [DW-1:0] exp_data;
		int req_count;
		done_vec = 3'b000;
		req_count = 0;
		while (done_vec == 3'b000) begin
			@(negedge clk);
			done_vec = {data_wr_done, data_rd_done, instr_rd_done};
			if (mem_req) begin
				req_count++;
				check_bus(r);
			end
		end
		assert (req_count == 1) else begin
			other_errors++;
			$display("row %0d saw %0d memory requests instead of one", r, req_count);
		end
		assert (done_vec == done_mask(rows[r].port)) else begin
			value_errors++;
			$display("ERROR row %0d {data_wr_done, data_rd_done, instr_rd_done} = 0x%h, %s0x%h",
				r, done_vec, "expected ", done_mask(rows[r].port));
		end
		assert (error == rows[r].exp_error) else begin
			value_errors++;
			$display("ERROR row %0d error = 0x%h, expected 0x%h", r, error, rows[r].exp_error);
		end
		if (rows[r].port == port_data_write) begin
			if (!rows[r].exp_error) begin
				ref_mem[rows[r].addr] = rows[r].wdata;
				ref_written[rows[r].addr] = 1'b1;
			end
		end else begin
			exp_data = rows[r].exp_error ? '0 : expected_word(rows[r].addr);
			assert (rd_data == exp_data) else begin
				value_errors++;
				$display("ERROR row %0d rd_data = 0x%h, expected 0x%h", r, rd_data, exp_data);
			end
		end
	endtask

	// ==================================================
	// run limit
	// ==================================================
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("errors: %0d value, %0d other", value_errors, other_errors + 1);
			$display("Testbench failed");
			$finish;
		end
	end

	// ==================================================
	// main sequence
	// ==================================================
	initial begin
		int first;
		int last;
		reset = 1'b1;
		instr_rd_req = 1'b0;
		data_rd_req = 1'b0;
		data_wr_req = 1'b0;
		instr_rd_addr = '0;
		data_rd_addr = '0;
		data_wr_addr = '0;
		data_wr_data = '0;
		mem_latency = 8'd0;
		value_errors = 0;
		other_errors = 0;
		cycle_count = 0;
		ref_written = '{default: 1'b0};
		build_table();
		cycle_limit = 10 + 20;	// reset and idle tail
		for (int i = 0; i < NUM_ROWS; i++) begin
			cycle_limit += (rows[i].latency == 8'd0) ? TIMEOUT_CYCLES : int'(rows[i].latency);
			cycle_limit += 8;
		end

		repeat (10) @(negedge clk);
		reset = 1'b0;
		assert (!mem_req && !instr_rd_done && !data_rd_done && !data_wr_done
			&& !instr_rd_full && !data_rd_full && !data_wr_full) else begin
			other_errors++;
			$display("outputs not idle after reset");
		end

		first = 0;
		while (first < NUM_ROWS) begin
			last = first;
			while (rows[last].with_next) begin
				last++;
			end
			assert (!instr_rd_full && !data_rd_full && !data_wr_full) else begin
				other_errors++;
				$display("a request FIFO is full before row %0d", first);
			end
			strobe_group(first, last);
			for (int r = first; r <= last; r++) begin
				check_row(r);
				if (r < last) begin
					mem_latency = rows[r + 1].latency;
				end
			end
			first = last + 1;
		end

		// no stray done pulses after the last row
		repeat (20) begin
			@(negedge clk);
			assert (!instr_rd_done && !data_rd_done && !data_wr_done) else begin
				other_errors++;
				$display("done pulse without a pending request");
			end
		end

		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
source/mem_access_pkg.sv
source/mem_req_if.sv
source/mem_request_fifo.sv
source/mem_bus_timer.sv
source/mem_bus_guard.sv
source/mem_access_via_fifos.sv
test/tb_mem_model.sv
test/tb_mem_access_via_fifos.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f all.f \
	--top-module tb_mem_access_via_fifos -o tb_sim &&
	./obj_dir/tb_sim; } > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0
